// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary -Wno-fatal --top-module tb_pipeline -f build.f > sim.log 2>&1
	./obj_dir/Vtb_pipeline >> sim.log 2>&1
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: build.f
+incdir+tb
design/pipe_pkg.sv
design/stage_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/retire_stage.sv
design/pipeline_control.sv
design/pipeline_top.sv
tb/tb_pipeline.sv

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic clk,
  input  logic rst,
  stage_if.dst ifid,
  stage_if.src idex,
  output logic load_use_o
);
  import pipe_pkg::*;

  logic            idex_valid_q;
  logic [PC_W-1:0] idex_pc_q;
  uop_t            idex_uop_q;

  logic id_reads_regs; // IF/ID word has source registers
  logic ex_is_load;
  logic rs_hit;

  always_comb begin
    id_reads_regs = 1'b0;
    rs_hit        = 1'b0;
    if (ifid.tok.valid) begin
      case (ifid.tok.uop.reg_view.op)
        OP_ALU, OP_LOAD, OP_MUL: id_reads_regs = 1'b1;
        default:                 id_reads_regs = 1'b0;
      endcase
    end
    // register fields only mean something for reg-type words
    if (id_reads_regs) begin
      rs_hit = (ifid.tok.uop.reg_view.rs1 == idex_uop_q.reg_view.rd) ||
               (ifid.tok.uop.reg_view.rs2 == idex_uop_q.reg_view.rd);
    end
  end

  assign ex_is_load = idex_valid_q && (idex_uop_q.reg_view.op == OP_LOAD);
  assign load_use_o = ex_is_load && rs_hit;

  // ID/EX register
  always_ff @(posedge clk) begin
    if (rst || idex.flush) begin
      idex_valid_q <= 1'b0;
    end else if (!idex.stall) begin
      idex_valid_q <= ifid.tok.valid && !ifid.stall; // bubble behind a held IF/ID
    end
  end

  always_ff @(posedge clk) begin
    if (!idex.stall) begin
      idex_pc_q  <= ifid.tok.pc;
      idex_uop_q <= ifid.tok.uop;
    end
  end

  assign idex.tok = '{valid: idex_valid_q, pc: idex_pc_q, uop: idex_uop_q};

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  logic                      clk,
  input  logic                      rst,
  stage_if.dst                      idex,
  stage_if.src                      exmem,
  output logic                      jump_o,
  output logic                      mul_busy_o,
  output logic [pipe_pkg::PC_W-1:0] jump_target_o
);
  import pipe_pkg::*;

  logic                 exmem_valid_q;
  logic [PC_W-1:0]      exmem_pc_q;
  uop_t                 exmem_uop_q;
  logic [MUL_CNT_W-1:0] mul_cnt_q;
  logic                 ex_is_mul;

  // jump resolves in EX
  assign jump_o        = idex.tok.valid && (idex.tok.uop.jmp_view.op == OP_JUMP);
  assign jump_target_o = idex.tok.uop.jmp_view.target;

  assign ex_is_mul  = idex.tok.valid && (idex.tok.uop.reg_view.op == OP_MUL);
  // busy until the last of MUL_CYCLES cycles in EX
  assign mul_busy_o = ex_is_mul && (mul_cnt_q != MUL_CNT_W'(MUL_CYCLES - 1));

  // cycles the current ID/EX token has been held
  always_ff @(posedge clk) begin
    if (rst || idex.flush || !idex.stall) begin
      mul_cnt_q <= '0; // token leaves or is killed
    end else if (mul_busy_o) begin
      mul_cnt_q <= mul_cnt_q + 1'b1;
    end
  end

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (rst || exmem.flush) begin
      exmem_valid_q <= 1'b0;
    end else if (!exmem.stall) begin
      exmem_valid_q <= idex.tok.valid && !idex.stall;
    end
  end

  always_ff @(posedge clk) begin
    if (!exmem.stall) begin
      exmem_pc_q  <= idex.tok.pc;
      exmem_uop_q <= idex.tok.uop;
    end
  end

  assign exmem.tok = '{valid: exmem_valid_q, pc: exmem_pc_q, uop: exmem_uop_q};

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  pipe_pkg::uop_t            instr_i,
  input  logic                      redirect_jump_i,
  input  logic                      redirect_trap_i,
  input  logic [pipe_pkg::PC_W-1:0] jump_target_i,
  output logic [pipe_pkg::PC_W-1:0] pc_o,
  stage_if.src                      ifid,
  stage_if.dst                      ctl_pc
);
  import pipe_pkg::*;

  logic [PC_W-1:0] pc_q;
  logic [PC_W-1:0] pc_next;
  logic            ifid_valid_q;
  logic [PC_W-1:0] ifid_pc_q;
  uop_t            ifid_uop_q;

  // trap redirect wins over a jump
  always_comb begin
    if (redirect_trap_i) begin
      pc_next = TRAP_VECTOR;
    end else if (redirect_jump_i) begin
      pc_next = jump_target_i;
    end else begin
      pc_next = pc_q + 1'b1;
    end
  end

  // redirects only land when the PC is not held by a ram stall
  always_ff @(posedge clk) begin
    if (rst || ctl_pc.flush) begin
      pc_q <= '0;
    end else if (!ctl_pc.stall) begin
      pc_q <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || ifid.flush) begin
      ifid_valid_q <= 1'b0;
    end else if (!ifid.stall) begin
      ifid_valid_q <= !ctl_pc.stall; // held pc feeds a bubble
    end
  end

  always_ff @(posedge clk) begin
    if (!ifid.stall) begin
      ifid_pc_q  <= pc_q;
      ifid_uop_q <= instr_i;
    end
  end

  assign ifid.tok = '{valid: ifid_valid_q, pc: ifid_pc_q, uop: ifid_uop_q};
  assign pc_o     = pc_q;

endmodule

`default_nettype wire

// File: design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  localparam int PC_W = 12;
  localparam logic [PC_W-1:0] TRAP_VECTOR = 12'h100; // fetch resumes here after a trap

  localparam int MUL_CYCLES = 4; // cycles a mul sits in EX
  localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);

  // bit positions in the stall and flush masks
  localparam int B_PC    = 0;
  localparam int B_IFID  = 1;
  localparam int B_IDEX  = 2;
  localparam int B_EXMEM = 3;
  localparam int B_MEMWB = 4;
  localparam int B_WB    = 5;
  localparam int MASK_W  = B_WB + 1;

  localparam logic [MASK_W-1:0] RAM_MEM_STALL  = 6'b001111;
  localparam logic [MASK_W-1:0] RAM_MEM_FLUSH  = MASK_W'(1) << B_MEMWB;
  localparam logic [MASK_W-1:0] RAM_IF_STALL   = 6'b001111; // same freeze as mem side
  localparam logic [MASK_W-1:0] RAM_IF_FLUSH   = 6'b000000;
  localparam logic [MASK_W-1:0] TRAP_STALL     = 6'b000010;
  localparam logic [MASK_W-1:0] TRAP_FLUSH     = 6'b001110;
  localparam logic [MASK_W-1:0] JUMP_STALL     = 6'b000010;
  localparam logic [MASK_W-1:0] JUMP_FLUSH     = 6'b000110;
  localparam logic [MASK_W-1:0] MUL_STALL      = 6'b000111;
  localparam logic [MASK_W-1:0] MUL_FLUSH      = 6'b001000;
  localparam logic [MASK_W-1:0] LOAD_USE_STALL = 6'b000011;
  localparam logic [MASK_W-1:0] LOAD_USE_FLUSH = 6'b000100;
  localparam logic [MASK_W-1:0] RESET_FLUSH    = 6'b011111;

  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_ALU  = 4'h1,
    OP_LOAD = 4'h2,
    OP_MUL  = 4'h3,
    OP_JUMP = 4'h4,
    OP_TRAP = 4'h5
  } op_e;

  // one micro-op word, two decodings sharing the opcode nibble
  typedef union packed {
    struct packed {
      op_e        op;
      logic [3:0] rd;
      logic [3:0] rs1;
      logic [3:0] rs2;
    } reg_view;
    struct packed {
      op_e             op;
      logic [PC_W-1:0] target; // word address
    } jmp_view;
  } uop_t;

  typedef struct packed {
    logic            valid;
    logic [PC_W-1:0] pc;
    uop_t            uop;
  } token_t;

endpackage

`default_nettype wire

// File: design/pipeline_control.sv
`timescale 1ns/1ps
`default_nettype none

// hazard arbiter, later stages take priority
module pipeline_control (
  input  logic                        rst,
  input  logic                        load_use_i,     // from decode
  input  logic                        jump_i,         // from execute
  input  logic                        mul_busy_i,     // from execute
  input  logic                        trap_i,         // from retire
  input  logic                        ram_if_busy_i,
  input  logic                        ram_mem_busy_i,
  output logic [pipe_pkg::MASK_W-1:0] stall_o,
  output logic [pipe_pkg::MASK_W-1:0] flush_o
);
  import pipe_pkg::*;

  always_comb begin
    if (rst) begin
      stall_o = '0;
      flush_o = RESET_FLUSH;
    end else if (ram_mem_busy_i) begin
      // data side busy, freeze up to EX/MEM
      stall_o = RAM_MEM_STALL;
      flush_o = RAM_MEM_FLUSH;
    end else if (ram_if_busy_i) begin
      stall_o = RAM_IF_STALL;
      flush_o = RAM_IF_FLUSH;
    end else if (trap_i) begin
      // drop everything younger than the trap
      stall_o = TRAP_STALL;
      flush_o = TRAP_FLUSH;
    end else if (jump_i) begin
      stall_o = JUMP_STALL;
      flush_o = JUMP_FLUSH;
    end else if (mul_busy_i) begin
      // hold the mul in EX, bubbles go down
      stall_o = MUL_STALL;
      flush_o = MUL_FLUSH;
    end else if (load_use_i) begin
      stall_o = LOAD_USE_STALL; // one bubble into ID/EX
      flush_o = LOAD_USE_FLUSH;
    end else begin
      stall_o = '0;
      flush_o = '0;
    end
  end

endmodule

`default_nettype wire

// File: design/pipeline_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [15:0]                 instr_i,
  input  logic                        ram_if_busy_i,
  input  logic                        ram_mem_busy_i,
  output logic [pipe_pkg::PC_W-1:0]   fetch_pc_o,
  output logic                        retire_valid_o,
  output logic [pipe_pkg::PC_W-1:0]   retire_pc_o,
  output logic [3:0]                  retire_rd_o,
  output logic [pipe_pkg::MASK_W-1:0] stall_o,
  output logic [pipe_pkg::MASK_W-1:0] flush_o
);
  import pipe_pkg::*;

  logic            load_use;
  logic            jump;
  logic            mul_busy;
  logic            trap;
  logic [PC_W-1:0] jump_target;

  stage_if ctl_pc (); // PC control only
  stage_if ifid ();
  stage_if idex ();
  stage_if exmem ();

  // each register gets its own mask bits
  assign ctl_pc.stall = stall_o[B_PC];
  assign ctl_pc.flush = flush_o[B_PC];
  assign ifid.stall   = stall_o[B_IFID];
  assign ifid.flush   = flush_o[B_IFID];
  assign idex.stall   = stall_o[B_IDEX];
  assign idex.flush   = flush_o[B_IDEX];
  assign exmem.stall  = stall_o[B_EXMEM];
  assign exmem.flush  = flush_o[B_EXMEM];

  fetch_stage u_fetch (
    .clk             (clk),
    .rst             (rst),
    .instr_i         (instr_i),
    .redirect_jump_i (jump),
    .redirect_trap_i (trap),
    .jump_target_i   (jump_target),
    .pc_o            (fetch_pc_o),
    .ifid            (ifid.src),
    .ctl_pc          (ctl_pc.dst)
  );

  decode_stage u_decode (
    .clk        (clk),
    .rst        (rst),
    .ifid       (ifid.dst),
    .idex       (idex.src),
    .load_use_o (load_use)
  );

  execute_stage u_execute (
    .clk           (clk),
    .rst           (rst),
    .idex          (idex.dst),
    .exmem         (exmem.src),
    .jump_o        (jump),
    .mul_busy_o    (mul_busy),
    .jump_target_o (jump_target)
  );

  retire_stage u_retire (
    .clk            (clk),
    .rst            (rst),
    .exmem          (exmem.dst),
    .trap_o         (trap),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o)
  );

  pipeline_control u_control (
    .rst            (rst),
    .load_use_i     (load_use),
    .jump_i         (jump),
    .mul_busy_i     (mul_busy),
    .trap_i         (trap),
    .ram_if_busy_i  (ram_if_busy_i),
    .ram_mem_busy_i (ram_mem_busy_i),
    .stall_o        (stall_o),
    .flush_o        (flush_o)
  );

endmodule

`default_nettype wire

// File: design/retire_stage.sv
`timescale 1ns/1ps
`default_nettype none

module retire_stage (
  input  logic                      clk,
  input  logic                      rst,
  stage_if.dst                      exmem,
  output logic                      trap_o,
  output logic                      retire_valid_o,
  output logic [pipe_pkg::PC_W-1:0] retire_pc_o,
  output logic [3:0]                retire_rd_o
);
  import pipe_pkg::*;

  logic            memwb_valid_q;
  logic [PC_W-1:0] memwb_pc_q;
  uop_t            memwb_uop_q;

  // trap raised as it enters MEM/WB, so every younger token is still flushable
  assign trap_o = exmem.tok.valid && (exmem.tok.uop.jmp_view.op == OP_TRAP);

  // MEM/WB never holds
  // a held EX/MEM leaves a bubble here, otherwise the same token would retire twice
  always_ff @(posedge clk) begin
    if (rst) begin
      memwb_valid_q <= 1'b0;
    end else begin
      memwb_valid_q <= exmem.tok.valid && !exmem.stall;
    end
  end

  always_ff @(posedge clk) begin
    memwb_pc_q  <= exmem.tok.pc;
    memwb_uop_q <= exmem.tok.uop;
  end

  assign retire_valid_o = memwb_valid_q;
  assign retire_pc_o    = memwb_pc_q;

  // only reg-type words write a destination
  always_comb begin
    case (memwb_uop_q.reg_view.op)
      OP_ALU, OP_LOAD, OP_MUL: retire_rd_o = memwb_uop_q.reg_view.rd;
      default:                 retire_rd_o = 4'h0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// one pipeline token plus the hazard bits of the register driving it
interface stage_if;
  import pipe_pkg::*;

  token_t tok;   // output of the upstream register
  logic   stall; // hold request for the register driving tok
  logic   flush; // clear request for that register

  // upstream register drives the token and sees its own control bits
  modport src (
    output tok,
    input  stall,
    input  flush
  );

  // downstream register also reads stall to spot a held upstream register
  modport dst (
    input tok,
    input stall,
    input flush
  );

endinterface

`default_nettype wire

// File: tb/tb_program.svh
// test rows: start pc, retirements with the dispatch jump at pc 0, mode,
// then expected cycles of LOAD_USE_STALL, MUL_STALL and JUMP_FLUSH (-1 skips)
// mode 0 plain, 1 adds the 4-cycle latency check, 2 adds random ram busy
localparam int N_TESTS = 7;

int tests [N_TESTS][6] = '{
  '{'h010, 9, 1, 0, 0, 1},      // straight alu: 0, 10..17
  '{'h020, 7, 0, 0, 0, 2},      // jump: 0, 20, 21, 30..33
  '{'h040, 6, 0, 1, 0, 1},      // load then dependent alu: 0, 40..44
  '{'h050, 6, 0, 0, 0, 1},      // load then independent alu: 0, 50..54
  '{'h060, 6, 0, 0, 3, 1},      // mul: 0, 60..64
  '{'h070, 6, 0, 0, 0, 1},      // trap: 0, 70, 71, 100..102
  '{'h080, 12, 2, -1, -1, -1}   // mixed: 0, 80..83, 90..93, 100..102
};

logic [15:0] prog [0:4095];

// words are {op, rd, rs1, rs2} or {op, target}
task automatic load_program();
  int a;
  for (a = 0; a < 4096; a++) begin
    prog[a] = {4'h1, a[11:0] ^ 12'h5a5}; // alu filler, fields follow the address
  end
  prog['h021] = 16'h4030; // jump to 030
  prog['h040] = 16'h2701; // load r7
  prog['h041] = 16'h1378; // reads r7
  prog['h050] = 16'h2701;
  prog['h051] = 16'h1389; // no r7 here
  prog['h060] = 16'h3412; // mul r4
  prog['h071] = 16'h5000; // trap
  prog['h080] = 16'h2901; // load r9
  prog['h081] = 16'h1190; // reads r9
  prog['h082] = 16'h3234;
  prog['h083] = 16'h4090; // jump to 090
  prog['h091] = 16'h2a00; // load ra, next word does not read it
  prog['h093] = 16'h5000;
endtask

// File: tb/tb_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipeline;
  import pipe_pkg::*;

  logic              clk;
  logic              rst;
  logic [15:0]       instr_i;
  logic              ram_if_busy_i;
  logic              ram_mem_busy_i;
  logic [PC_W-1:0]   fetch_pc_o;
  logic              retire_valid_o;
  logic [PC_W-1:0]   retire_pc_o;
  logic [3:0]        retire_rd_o;
  logic [MASK_W-1:0] stall_o;
  logic [MASK_W-1:0] flush_o;
  integer            seed = 37396;
  int                errors = 0;
  int                fetch_cycle [0:4095]; // last cycle each pc sat on fetch_pc_o
  string             mask_name [3] = '{"stall_o LOAD_USE_STALL cycles",
                                       "stall_o MUL_STALL cycles", "flush_o JUMP_FLUSH cycles"};

  `include "tb_program.svh"

  pipeline_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // pc 0 holds a jump to the first word of the test
  function automatic logic [15:0] program_word(input logic [PC_W-1:0] pc, input int start);
    return (pc == 0) ? {OP_JUMP, start[PC_W-1:0]} : prog[pc];
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] exp_v, act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  initial begin
    logic [PC_W-1:0] exp_pc;
    logic [15:0]     w;
    logic            prev_mem;
    int              n_ret;
    int              cyc;
    int              err0;
    int              seen [3];
    rst = 1'b1;
    instr_i = '0;
    load_program();
    for (int t = 0; t < N_TESTS; t++) begin
      rst = 1'b1;
      ram_if_busy_i = 1'b0;
      ram_mem_busy_i = 1'b0;
      repeat (15) @(posedge clk);
      @(negedge clk);
      expect_equal("retire_valid_o", 0, retire_valid_o);
      expect_equal("fetch_pc_o", 0, fetch_pc_o);
      exp_pc = '0;
      prev_mem = 1'b0;
      n_ret = 0;
      cyc = 0;
      err0 = errors;
      seen = '{0, 0, 0};
      @(posedge clk);
      #1 rst = 1'b0;
      while (n_ret < tests[t][1]) begin
        instr_i = program_word(fetch_pc_o, tests[t][0]);
        if (tests[t][2] == 2) begin
          ram_if_busy_i  = ($random(seed) & 3) == 0;
          ram_mem_busy_i = ($random(seed) & 3) == 0;
        end
        @(negedge clk);
        seen[0] += (stall_o == LOAD_USE_STALL);
        seen[1] += (stall_o == MUL_STALL);
        seen[2] += (flush_o == JUMP_FLUSH);
        fetch_cycle[fetch_pc_o] = cyc;
        // MEM/WB takes a bubble behind a ram_mem_busy_i cycle
        if (prev_mem) expect_equal("retire_valid_o", 0, retire_valid_o);
        if (retire_valid_o) begin
          w = program_word(exp_pc, tests[t][0]);
          expect_equal("retire_pc_o", exp_pc, retire_pc_o);
          expect_equal("retire_rd_o",
                       (w[15:12] inside {OP_ALU, OP_LOAD, OP_MUL}) ? w[11:8] : 4'h0, retire_rd_o);
          if (tests[t][2] == 1) expect_equal("retire latency", 4, cyc - fetch_cycle[exp_pc]);
          // a jump continues at its target and a trap at the vector
          if (w[15:12] == OP_JUMP) exp_pc = w[PC_W-1:0];
          else if (w[15:12] == OP_TRAP) exp_pc = TRAP_VECTOR;
          else exp_pc = exp_pc + 1'b1;
          n_ret++;
        end
        prev_mem = ram_mem_busy_i;
        cyc++;
        @(posedge clk);
        #1;
      end
      for (int k = 0; k < 3; k++) begin
        if (tests[t][3+k] >= 0) expect_equal(mask_name[k], tests[t][3+k], seen[k]);
      end
      $display("test %0d at pc %0h: %0d retired, %0d errors", t, tests[t][0], n_ret,
               errors - err0);
    end
    $display("%0d tests run, %0d errors", N_TESTS, errors);
    if (errors == 0) $display("Simulation PASSED");
    else $display("Simulation FAILED");
    $finish;
  end

  // limit scales with the retirements each test expects
  initial begin
    int limit;
    limit = 0;
    for (int i = 0; i < N_TESTS; i++) limit += tests[i][1] * (MUL_CYCLES + 8) + 100 + 17;
    #(limit * 20);
    $display("timeout: the tests did not finish within %0d cycles", limit);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
